// File: source/pdp8_macros.svh
`ifndef PDP8_MACROS_SVH
`define PDP8_MACROS_SVH

`define WORD_W          12
`define MEM_DEPTH       4096

// auto-index locations on page zero
`define AUTOINDEX_BASE  12'o0010
`define AUTOINDEX_TOP   12'o0017

`define REG_SR          5'h00
`define REG_CMD         5'h04  // write only
`define REG_ADDR        5'h08
`define REG_DATA        5'h0C
`define REG_STATUS      5'h10
`define REG_AC          5'h14

`endif

// File: source/pdp8_pkg.sv
`default_nettype none

`include "pdp8_macros.svh"

package pdp8_pkg;

  typedef enum logic [3:0] {
    H0, H1,
    F0, FW, F1, F2,
    D0, DW, D1, D2,
    E0, EW, E1, E2
  } major_state_e;

  typedef enum logic [2:0] {
    AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
  } opcode_e;

  typedef struct packed {
    logic               load_addr;
    logic               deposit;
    logic               examine;
    logic               start;
    logic               halt;
    logic [`WORD_W-1:0] sr;         // switch register
  } panel_cmd_t;

  typedef struct packed {
    opcode_e op;
    logic    indirect;
    logic    index;                   // pointer is an auto-index location
    logic    isz_skip;
  } decode_t;

  typedef struct packed {
    logic [`WORD_W-1:0] addr;
    logic [`WORD_W-1:0] wdata;
    logic               we;
  } mem_bus_t;

endpackage

`default_nettype wire

// File: source/core_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "pdp8_macros.svh"

module core_ram (
  input  logic                clk,
  input  pdp8_pkg::mem_bus_t  mem,
  output logic [`WORD_W-1:0]  rdata
);

  logic [`WORD_W-1:0] ram [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (mem.we) begin
      ram[mem.addr] <= mem.wdata;
      rdata <= mem.wdata;  // write-first
    end else begin
      rdata <= ram[mem.addr];
    end
  end

endmodule

`default_nettype wire

// File: source/panel_apb.sv
`default_nettype none
`timescale 1ns/1ps

`include "pdp8_macros.svh"

module panel_apb (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [4:0]            paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output pdp8_pkg::panel_cmd_t  cmd,
  input  logic                  running,
  input  logic [`WORD_W-1:0]    addr,
  input  logic [`WORD_W-1:0]    mdata,
  input  logic [`WORD_W-1:0]    ac,
  input  logic                  link
);

  logic access;
  logic wr_sr;
  logic wr_cmd;
  logic refuse;
  logic cmd_ok;

  assign access = psel && penable;
  assign wr_sr  = access && pwrite && (paddr == `REG_SR);
  assign wr_cmd = access && pwrite && (paddr == `REG_CMD);

  // anything but halt is refused while the machine runs
  assign refuse = wr_cmd && running && (|pwdata[3:0]);
  assign cmd_ok = wr_cmd && !running;

  assign pready  = 1'b1;
  assign pslverr = refuse;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd <= '0;
    end else begin
      cmd.load_addr <= cmd_ok && pwdata[0];  // one-cycle strobes
      cmd.deposit   <= cmd_ok && pwdata[1];
      cmd.examine   <= cmd_ok && pwdata[2];
      cmd.start     <= cmd_ok && pwdata[3];
      cmd.halt      <= wr_cmd && !refuse && pwdata[4];
      if (wr_sr) begin
        cmd.sr <= pwdata[`WORD_W-1:0];
      end
    end
  end

  // lamps
  always_comb begin
    case (paddr)
      `REG_SR:     prdata = 32'(cmd.sr);
      `REG_ADDR:   prdata = 32'(addr);
      `REG_DATA:   prdata = 32'(mdata);
      `REG_STATUS: prdata = 32'(running);
      `REG_AC:     prdata = 32'({link, ac});
      default:     prdata = '0;
    endcase
  end

  // an error response ends a proper setup then access sequence
  assert property (@(posedge clk) disable iff (reset)
    pslverr |-> psel && penable && $past(psel && !penable));

endmodule

`default_nettype wire

// File: source/major_state_seq.sv
`default_nettype none
`timescale 1ns/1ps

module major_state_seq (
  input  logic                    clk,
  input  logic                    reset,
  input  pdp8_pkg::panel_cmd_t    cmd,
  input  pdp8_pkg::decode_t       dec,
  input  logic                    halt_op,
  output pdp8_pkg::major_state_e  state,
  output logic                    running
);

  pdp8_pkg::major_state_e next_state;
  pdp8_pkg::major_state_e end_state;
  logic                   halt_req;
  logic                   exec_op;

  assign running = (state != pdp8_pkg::H0) && (state != pdp8_pkg::H1);

  // memory reference that needs the execute cycle
  assign exec_op = dec.op inside {pdp8_pkg::AND, pdp8_pkg::TAD, pdp8_pkg::ISZ,
                                  pdp8_pkg::DCA, pdp8_pkg::JMS};

  assign end_state = (halt_req || cmd.halt || halt_op) ? pdp8_pkg::H0 : pdp8_pkg::F0;

  always_comb begin
    next_state = state;
    case (state)
      pdp8_pkg::H0: begin
        if (cmd.start) begin
          next_state = pdp8_pkg::F0;
        end else if (cmd.load_addr || cmd.deposit || cmd.examine) begin
          next_state = pdp8_pkg::H1;
        end
      end
      pdp8_pkg::H1: next_state = pdp8_pkg::H0;
      pdp8_pkg::F0: next_state = pdp8_pkg::FW;
      pdp8_pkg::FW: next_state = pdp8_pkg::F1;
      pdp8_pkg::F1: next_state = pdp8_pkg::F2;
      pdp8_pkg::F2: begin
        if (dec.op inside {pdp8_pkg::IOT, pdp8_pkg::OPR}) begin
          next_state = end_state;
        end else if (dec.indirect) begin
          next_state = pdp8_pkg::D0;
        end else if (exec_op) begin
          next_state = pdp8_pkg::E0;
        end else begin
          next_state = end_state;  // direct jmp
        end
      end
      pdp8_pkg::D0: next_state = pdp8_pkg::DW;
      pdp8_pkg::DW: next_state = pdp8_pkg::D1;
      pdp8_pkg::D1: next_state = pdp8_pkg::D2;
      pdp8_pkg::D2: next_state = exec_op ? pdp8_pkg::E0 : end_state;
      pdp8_pkg::E0: next_state = pdp8_pkg::EW;
      pdp8_pkg::EW: next_state = pdp8_pkg::E1;
      pdp8_pkg::E1: next_state = pdp8_pkg::E2;
      pdp8_pkg::E2: next_state = end_state;
      default:      next_state = pdp8_pkg::H0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= pdp8_pkg::H0;
      halt_req <= 1'b0;
    end else begin
      state <= next_state;
      if (!running) begin
        halt_req <= 1'b0;
      end else if (cmd.halt) begin
        halt_req <= 1'b1;  // held until the instruction ends
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    !running |=> !running || (state == pdp8_pkg::F0 && $past(cmd.start)));

  // auto-index flag lives only inside the defer cycle
  assert property (@(posedge clk) disable iff (reset)
    dec.index |-> state inside {pdp8_pkg::DW, pdp8_pkg::D1, pdp8_pkg::D2});

endmodule

`default_nettype wire

// File: source/memory_address.sv
`default_nettype none
`timescale 1ns/1ps

`include "pdp8_macros.svh"

module memory_address (
  input  logic                    clk,
  input  logic                    reset,
  input  pdp8_pkg::major_state_e  state,
  input  pdp8_pkg::panel_cmd_t    cmd,
  input  logic [`WORD_W-1:0]      rdata,
  input  logic [`WORD_W-1:0]      ac,
  input  logic                    skip,
  output pdp8_pkg::mem_bus_t      mem,
  output logic [`WORD_W-1:0]      addr,
  output logic [`WORD_W-1:0]      mdata,
  output logic [`WORD_W-1:0]      instruction,
  output pdp8_pkg::decode_t       dec
);

  logic [`WORD_W-1:0] pc;
  logic [`WORD_W-1:0] next_pc;
  logic [`WORD_W-1:0] skip_pc;
  logic [`WORD_W-1:0] eff_addr;
  logic               index;
  logic               pend_load;
  logic               pend_dep;
  logic               pend_exam;

  // page zero or current page
  assign eff_addr = {instruction[7] ? pc[11:7] : 5'b00000, instruction[6:0]};

  always_comb begin
    dec.op       = pdp8_pkg::opcode_e'(instruction[11:9]);
    dec.indirect = instruction[8];
    dec.index    = index;
    dec.isz_skip = (dec.op == pdp8_pkg::ISZ) && (mdata == '1);
  end

  always_comb begin
    mem.addr  = addr;
    mem.we    = 1'b0;
    mem.wdata = mdata + 1'b1;  // auto-index and isz
    case (state)
      pdp8_pkg::D1: mem.we = index;
      pdp8_pkg::E1: begin
        case (dec.op)
          pdp8_pkg::ISZ: mem.we = 1'b1;
          pdp8_pkg::DCA: begin
            mem.we    = 1'b1;
            mem.wdata = ac;
          end
          pdp8_pkg::JMS: begin
            mem.we    = 1'b1;
            mem.wdata = next_pc;  // return address
          end
          default: ;
        endcase
      end
      pdp8_pkg::H1: begin
        mem.we    = pend_dep && !pend_load;
        mem.wdata = cmd.sr;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      addr        <= '0;
      instruction <= 12'o7000;
      index       <= 1'b0;
      pend_load   <= 1'b0;
      pend_dep    <= 1'b0;
      pend_exam   <= 1'b0;
    end else begin
      case (state)
        pdp8_pkg::H0: begin
          pend_load <= cmd.load_addr;
          pend_dep  <= cmd.deposit;
          pend_exam <= cmd.examine;
        end
        pdp8_pkg::H1: begin
          if (pend_load) begin
            addr <= cmd.sr;
          end else if (pend_dep || pend_exam) begin
            addr <= addr + 1'b1;
          end
        end
        pdp8_pkg::FW: instruction <= rdata;
        pdp8_pkg::F2: begin
          if (dec.op inside {pdp8_pkg::IOT, pdp8_pkg::OPR}) begin
            addr <= skip ? skip_pc : next_pc;
          end else begin
            addr <= eff_addr;  // jmp lands here directly
          end
        end
        pdp8_pkg::D0: index <= addr inside {[`AUTOINDEX_BASE:`AUTOINDEX_TOP]};
        pdp8_pkg::D2: begin
          addr  <= mdata;  // pointer, already bumped when indexed
          index <= 1'b0;
        end
        pdp8_pkg::E2: addr <= (dec.op == pdp8_pkg::JMS) ? addr + 1'b1 : next_pc;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      pdp8_pkg::H1: begin
        if (pend_dep && !pend_load) begin
          mdata <= cmd.sr;
        end else if (pend_exam && !pend_load) begin
          mdata <= rdata;
        end
      end
      pdp8_pkg::F0: pc <= addr;
      pdp8_pkg::FW: mdata <= rdata;
      pdp8_pkg::F1: begin
        next_pc <= pc + 12'd1;
        skip_pc <= pc + 12'd2;
      end
      pdp8_pkg::DW: mdata <= rdata;
      pdp8_pkg::D1: if (index) mdata <= mdata + 1'b1;
      pdp8_pkg::EW: mdata <= rdata;
      pdp8_pkg::E1: begin
        if (dec.op == pdp8_pkg::ISZ) begin
          mdata <= mdata + 1'b1;
          if (dec.isz_skip) next_pc <= skip_pc;
        end
      end
      default: ;
    endcase
  end

  // panel writes only follow a deposit strobe
  assert property (@(posedge clk) disable iff (reset)
    mem.we |-> state inside {pdp8_pkg::D1, pdp8_pkg::E1} ||
               (state == pdp8_pkg::H1 && $past(cmd.deposit)));

endmodule

`default_nettype wire

// File: source/accumulator.sv
`default_nettype none
`timescale 1ns/1ps

`include "pdp8_macros.svh"

module accumulator (
  input  logic                    clk,
  input  logic                    reset,
  input  pdp8_pkg::major_state_e  state,
  input  logic [`WORD_W-1:0]      instruction,
  input  logic [`WORD_W-1:0]      mdata,
  output logic [`WORD_W-1:0]      ac,
  output logic                    link,
  output logic                    skip,
  output logic                    halt_op
);

  pdp8_pkg::opcode_e  op;
  logic               grp1;
  logic               grp2;
  logic               cond;
  logic [`WORD_W-1:0] g1_ac;
  logic               g1_link;

  assign op   = pdp8_pkg::opcode_e'(instruction[11:9]);
  assign grp1 = (op == pdp8_pkg::OPR) && !instruction[8];
  assign grp2 = (op == pdp8_pkg::OPR) && instruction[8] && !instruction[0];

  // group 1 sequence, clear then complement then increment
  always_comb begin
    g1_ac   = instruction[7] ? '0 : ac;
    g1_link = instruction[6] ? 1'b0 : link;
    if (instruction[5]) g1_ac = ~g1_ac;
    if (instruction[4]) g1_link = ~g1_link;
    {g1_link, g1_ac} = {g1_link, g1_ac} + {{`WORD_W{1'b0}}, instruction[0]};
  end

  // sma sza snl, bit 3 reverses the sense
  assign cond = (instruction[6] && ac[`WORD_W-1]) ||
                (instruction[5] && (ac == '0)) ||
                (instruction[4] && link);
  assign skip    = grp2 && (cond ^ instruction[3]);
  assign halt_op = grp2 && instruction[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (state)
        pdp8_pkg::F2: begin
          if (grp1) begin
            ac   <= g1_ac;
            link <= g1_link;
          end else if (grp2 && instruction[7]) begin
            ac <= '0;  // cla after the skip test
          end
        end
        pdp8_pkg::E1: begin
          if (op == pdp8_pkg::AND) begin
            ac <= ac & mdata;
          end else if (op == pdp8_pkg::TAD) begin
            {link, ac} <= {link, ac} + {1'b0, mdata};  // carry flips link
          end
        end
        pdp8_pkg::E2: if (op == pdp8_pkg::DCA) ac <= '0;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/pdp8_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "pdp8_macros.svh"

module pdp8_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  pdp8_pkg::panel_cmd_t   cmd;
  pdp8_pkg::decode_t      dec;
  pdp8_pkg::major_state_e state;
  pdp8_pkg::mem_bus_t     mem;
  logic                   running;
  logic                   halt_op;
  logic                   skip;
  logic                   link;
  logic [`WORD_W-1:0]     rdata;
  logic [`WORD_W-1:0]     addr;
  logic [`WORD_W-1:0]     mdata;
  logic [`WORD_W-1:0]     instruction;
  logic [`WORD_W-1:0]     ac;

  panel_apb panel_apb_i (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .cmd, .running, .addr, .mdata, .ac, .link
  );

  major_state_seq major_state_seq_i (
    .clk, .reset, .cmd, .dec, .halt_op, .state, .running
  );

  memory_address memory_address_i (
    .clk, .reset, .state, .cmd, .rdata, .ac, .skip,
    .mem, .addr, .mdata, .instruction, .dec
  );

  accumulator accumulator_i (
    .clk, .reset, .state, .instruction, .mdata, .ac, .link, .skip, .halt_op
  );

  core_ram core_ram_i (
    .clk, .mem, .rdata
  );

endmodule

`default_nettype wire

// File: tests/pdp8_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "pdp8_macros.svh"

module pdp8_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int POLL_LIMIT  = 100;
  localparam int APB_BOUND   = 500;  // transfers over all tests rounded up
  localparam int PROG_INSTRS = 40;   // instructions over all program runs
  localparam int TIMEOUT_CYCLES = APB_BOUND * 5 + PROG_INSTRS * 12 + 500;

  logic        clk;
  logic        reset;
  logic [4:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [15:0] lfsr;
  logic        resp_err;
  int          checks;
  int          errors;

  pdp8_top pdp8_top_i (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [11:0] w);
    w = '0;
    for (int i = 0; i < 12; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[10:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s done, %0d errors", name, errors - errs_before);
  endtask

  task automatic apb_write(input logic [4:0] a, input logic [31:0] d, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    err = pslverr;  // mid access phase
    check("pready", {31'h0, pready}, 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] a, output logic [31:0] d);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    d = prdata;
    check("pready", {31'h0, pready}, 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // command strobe then let H1 finish
  task automatic send_command(input logic [31:0] bits, output logic err);
    apb_write(`REG_CMD, bits, err);
    repeat (2) @(negedge clk);
  endtask

  task automatic set_switches(input logic [11:0] w);
    apb_write(`REG_SR, {20'h0, w}, resp_err);
    check("pslverr", {31'h0, resp_err}, 32'h0);
  endtask

  task automatic load_address(input logic [11:0] a);
    set_switches(a);
    send_command(32'h01, resp_err);
    check("pslverr", {31'h0, resp_err}, 32'h0);
  endtask

  task automatic deposit_word(input logic [11:0] w);
    set_switches(w);
    send_command(32'h02, resp_err);
    check("pslverr", {31'h0, resp_err}, 32'h0);
  endtask

  task automatic examine_word(output logic [11:0] w);
    logic [31:0] d;
    send_command(32'h04, resp_err);
    check("pslverr", {31'h0, resp_err}, 32'h0);
    apb_read(`REG_DATA, d);
    w = d[11:0];
  endtask

  task automatic expect_word(input logic [11:0] a, input logic [11:0] exp);
    logic [11:0] w;
    load_address(a);
    examine_word(w);
    check($sformatf("mem[%o]", a), {20'h0, w}, {20'h0, exp});
  endtask

  task automatic wait_halt();
    logic [31:0] st;
    int          polls;
    polls = 0;
    st = 32'h1;
    while (st[0] && polls < POLL_LIMIT) begin
      apb_read(`REG_STATUS, st);
      polls++;
    end
    if (st[0]) begin
      $display("program still running after %0d status polls", polls);
      errors++;
    end
  endtask

  task automatic run_from(input logic [11:0] a);
    load_address(a);
    send_command(32'h08, resp_err);
    check("pslverr", {31'h0, resp_err}, 32'h0);
    wait_halt();
  endtask

  task automatic reset_defaults();
    logic [31:0] d;
    int          e0;
    e0 = errors;
    apb_read(`REG_STATUS, d);
    check("status", d, 32'h0);
    apb_read(`REG_ADDR, d);
    check("addr", d, 32'h0);
    apb_read(`REG_AC, d);
    check("ac", d, 32'h0);
    report_test("reset_state", e0);
  endtask

  task automatic deposit_examine_round_trip();
    logic [11:0] words [16];
    logic [11:0] start;
    logic [11:0] w;
    logic [31:0] d;
    int          e0;
    e0 = errors;
    start = 12'o2400;
    load_address(start);
    apb_read(`REG_ADDR, d);
    check("addr", d, {20'h0, start});
    for (int i = 0; i < 16; i++) begin
      random_word(words[i]);
      deposit_word(words[i]);
      apb_read(`REG_ADDR, d);
      check("addr", d, {20'h0, 12'(start + i + 1)});
    end
    load_address(start);
    for (int i = 0; i < 16; i++) begin
      examine_word(w);
      check($sformatf("mem[%o]", 12'(start + i)), {20'h0, w}, {20'h0, words[i]});
      apb_read(`REG_ADDR, d);
      check("addr", d, {20'h0, 12'(start + i + 1)});
    end
    report_test("deposit_examine", e0);
  endtask

  task automatic arithmetic_programs();
    logic [11:0] a_val;
    logic [11:0] b_val;
    logic [11:0] sum;
    logic [12:0] total;
    logic [31:0] d;
    int          e0;
    e0 = errors;
    random_word(a_val);
    random_word(b_val);
    sum = a_val + b_val;
    load_address(12'o0200);
    deposit_word(12'o1210);  // tad 0210
    deposit_word(12'o1211);  // tad 0211
    deposit_word(12'o3212);  // dca 0212
    deposit_word(12'o7402);  // hlt
    load_address(12'o0210);
    deposit_word(a_val);
    deposit_word(b_val);
    deposit_word(12'o0000);
    run_from(12'o0200);
    expect_word(12'o0212, sum);
    apb_read(`REG_AC, d);
    check("ac", {20'h0, d[11:0]}, 32'h0);
    // carry into link then mask
    total = 13'o7000 + 13'o1234;
    load_address(12'o0200);
    deposit_word(12'o7300);  // cla cll
    deposit_word(12'o1210);
    deposit_word(12'o1211);
    deposit_word(12'o0212);  // and 0212
    deposit_word(12'o7402);
    load_address(12'o0210);
    deposit_word(12'o7000);
    deposit_word(12'o1234);
    deposit_word(12'o0077);
    run_from(12'o0200);
    apb_read(`REG_AC, d);
    check("ac", d, {19'h0, total[12], total[11:0] & 12'o0077});
    report_test("arithmetic", e0);
  endtask

  task automatic control_flow_programs();
    logic [31:0] d;
    int          e0;
    e0 = errors;
    load_address(12'o0400);
    deposit_word(12'o2220);  // isz 0420
    deposit_word(12'o5200);  // jmp 0400
    deposit_word(12'o4230);  // jms 0430
    deposit_word(12'o7402);
    load_address(12'o0420);
    deposit_word(12'o7775);
    deposit_word(12'o0000);  // set by the subroutine
    load_address(12'o0430);
    deposit_word(12'o0000);
    deposit_word(12'o2221);  // isz 0421
    deposit_word(12'o5630);  // jmp i 0430
    run_from(12'o0400);
    apb_read(`REG_ADDR, d);
    check("addr", d, {20'h0, 12'o0404});
    expect_word(12'o0420, 12'o0000);
    expect_word(12'o0421, 12'o0001);
    expect_word(12'o0430, 12'o0403);
    report_test("control_flow", e0);
  endtask

  task automatic addressing_modes();
    logic [11:0] v;
    logic [11:0] x;
    int          e0;
    e0 = errors;
    random_word(v);
    random_word(x);
    load_address(12'o0600);
    deposit_word(12'o7300);
    deposit_word(12'o1410);  // tad i 0010
    deposit_word(12'o3240);  // dca 0640
    deposit_word(12'o1241);  // tad 0641
    deposit_word(12'o3242);  // dca 0642
    deposit_word(12'o7402);
    load_address(12'o0010);
    deposit_word(12'o0477);
    load_address(12'o0477);
    deposit_word(~v);  // only read if the pointer is not bumped
    deposit_word(v);
    load_address(12'o0641);
    deposit_word(x);
    run_from(12'o0600);
    expect_word(12'o0010, 12'o0500);
    expect_word(12'o0640, v);
    expect_word(12'o0642, x);
    report_test("addressing", e0);
  endtask

  task automatic panel_halt_and_operate();
    logic        err;
    logic [31:0] d;
    int          e0;
    e0 = errors;
    load_address(12'o1000);
    deposit_word(12'o5200);  // jmp to itself
    deposit_word(12'o0000);
    load_address(12'o1000);
    send_command(32'h08, err);
    apb_read(`REG_STATUS, d);
    check("status", d, 32'h1);
    set_switches(12'o7777);
    send_command(32'h02, err);
    check("pslverr", {31'h0, err}, 32'h1);
    send_command(32'h10, err);
    check("pslverr", {31'h0, err}, 32'h0);
    wait_halt();
    apb_read(`REG_ADDR, d);
    check("addr", d, {20'h0, 12'o1000});
    expect_word(12'o1000, 12'o5200);
    expect_word(12'o1001, 12'o0000);
    load_address(12'o1000);
    deposit_word(12'o7300);
    deposit_word(12'o7241);  // cla cma iac
    deposit_word(12'o7440);  // sza
    deposit_word(12'o7402);
    deposit_word(12'o7402);
    run_from(12'o1000);
    apb_read(`REG_ADDR, d);
    check("addr", d, {20'h0, 12'o1005});
    apb_read(`REG_AC, d);
    check("ac", d, 32'h1000);
    report_test("panel_operate", e0);
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not complete in the expected time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    lfsr    = 16'(74365);  // seed folded to 16 bits
    checks  = 0;
    errors  = 0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    reset_defaults();
    deposit_examine_round_trip();
    arithmetic_programs();
    control_flow_programs();
    addressing_modes();
    panel_halt_and_operate();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/pdp8_pkg.sv
source/core_ram.sv
source/panel_apb.sv
source/major_state_seq.sv
source/memory_address.sv
source/accumulator.sv
source/pdp8_top.sv
tests/pdp8_tb.sv
